// File: organ_pkg.sv
package organ_pkg;

  // ====================
  // Tone side widths
  // ====================

  // Note index, Do up to Do2
  typedef logic [2:0] note_t;

  // CLK_50M cycles per half wave
  typedef logic [15:0] half_period_t;

  // Signed byte sent to the audio path
  typedef logic signed [7:0] audio_sample_t;

  // Board switches for the tone generator
  typedef struct packed {
    note_t note;
    logic  tone_on;
  } organ_switches_t;

  // ====================
  // Note table
  // ====================

  // Half periods for Do Re Mi Fa So La Si Do2
  localparam half_period_t NOTE_HALF_PERIOD [0:7] = '{
    16'd47800,
    16'd42590,
    16'd37936,
    16'd35817,
    16'd31929,
    16'd28409,
    16'd25329,
    16'd23900
  };

  // Full scale levels of the square wave
  localparam audio_sample_t SAMPLE_HIGH = 8'sh7F;
  localparam audio_sample_t SAMPLE_LOW  = 8'sh80;

endpackage

// File: panel_pkg.sv
package panel_pkg;

  // ====================
  // Front panel widths
  // ====================

  // Red LED bank
  typedef logic [7:0] led_t;

  // One active-low digit, segments g down to a
  typedef logic [6:0] seg_t;

  // Six digits, digit 0 is the least significant
  typedef seg_t [5:0] hex_digits_t;

  // Scope sampling clock count
  typedef logic [15:0] sample_count_t;

  // ====================
  // Grouped panel signals
  // ====================

  // Push keys, all active low as on the board
  typedef struct packed {
    logic speed_up_n;
    logic speed_down_n;
    logic speed_reset_n;
  } panel_keys_t;

  // Single-cycle speed requests
  typedef struct packed {
    logic up;
    logic down;
    logic restore;
  } speed_events_t;

  // Tick enables in the CLK_50M domain
  typedef struct packed {
    logic ms_tick;
    logic display_tick;
    logic chase_tick;
  } panel_ticks_t;

  // Bouncing LED states, up to the top LED and back down
  typedef enum logic [3:0] {
    RISE_0, RISE_1, RISE_2, RISE_3,
    RISE_4, RISE_5, RISE_6, RISE_7,
    FALL_6, FALL_5, FALL_4, FALL_3,
    FALL_2, FALL_1
  } chase_state_t;

endpackage

// File: organ_control.sv
`timescale 1ns/10ps

module organ_control
  import panel_pkg::*;
#(
  parameter int CLKS_PER_MS    = 50000,
  parameter int MS_PER_REPEAT  = 100,
  parameter int MS_PER_DISPLAY = 500
)
(
  input  logic          CLK_50M,
  input  logic          rst,
  input  panel_keys_t   keys,
  output panel_ticks_t  ticks,
  output speed_events_t events
);

  localparam int MS_W  = $clog2(CLKS_PER_MS + 1);
  localparam int REP_W = $clog2(MS_PER_REPEAT + 1);
  localparam int DSP_W = $clog2(MS_PER_DISPLAY + 1);

  logic [MS_W-1:0]  ms_cnt;
  logic [DSP_W-1:0] dsp_cnt;
  logic [REP_W-1:0] rep_cnt;
  logic             ms_tick;
  logic             display_tick;
  logic             chase_tick;
  logic             chase_half;
  panel_keys_t      key_meta;
  panel_keys_t      key_sync;
  logic             repeat_wrap;
  logic             up_pulse;
  logic             down_pulse;

  // ====================
  // Divider chain
  // ====================

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      ms_cnt  <= '0;
      ms_tick <= 1'b0;
    end
    else if (ms_cnt == MS_W'(CLKS_PER_MS - 1))
    begin
      ms_cnt  <= '0;
      ms_tick <= 1'b1;
    end
    else
    begin
      ms_cnt  <= ms_cnt + 1'b1;
      ms_tick <= 1'b0;
    end
  end

  // Display refresh every MS_PER_DISPLAY ms, chase step every other refresh
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      dsp_cnt      <= '0;
      display_tick <= 1'b0;
      chase_half   <= 1'b0;
      chase_tick   <= 1'b0;
    end
    else
    begin
      display_tick <= 1'b0;
      chase_tick   <= 1'b0;
      if (ms_tick)
      begin
        if (dsp_cnt == DSP_W'(MS_PER_DISPLAY - 1))
        begin
          dsp_cnt      <= '0;
          display_tick <= 1'b1;
        end
        else
          dsp_cnt <= dsp_cnt + 1'b1;
      end
      if (display_tick)
      begin
        chase_half <= ~chase_half;
        chase_tick <= chase_half;
      end
    end
  end

  // ====================
  // Key path
  // ====================

  // Two flop synchronizer, released keys read as ones
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      key_meta <= '1;
      key_sync <= '1;
    end
    else
    begin
      key_meta <= keys;
      key_sync <= key_meta;
    end
  end

  assign repeat_wrap = ms_tick && (rep_cnt == REP_W'(MS_PER_REPEAT - 1));

  // Held keys give one event per repeat window
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      rep_cnt    <= '0;
      up_pulse   <= 1'b0;
      down_pulse <= 1'b0;
    end
    else
    begin
      up_pulse   <= repeat_wrap && !key_sync.speed_up_n;
      down_pulse <= repeat_wrap && !key_sync.speed_down_n;
      if (ms_tick)
        rep_cnt <= repeat_wrap ? '0 : rep_cnt + 1'b1;
    end
  end

  assign ticks = '{ms_tick: ms_tick, display_tick: display_tick, chase_tick: chase_tick};

  // Restore follows the synchronized key level directly
  assign events = '{up: up_pulse, down: down_pulse, restore: !key_sync.speed_reset_n};

  // Tick strobes never stretch
  assert property (@(posedge CLK_50M) disable iff (rst) ms_tick |=> !ms_tick);
  assert property (@(posedge CLK_50M) disable iff (rst) display_tick |=> !display_tick);
  assert property (@(posedge CLK_50M) disable iff (rst) chase_tick |=> !chase_tick);

  // A step event needs its key down at the pins three cycles before
  assert property (@(posedge CLK_50M) disable iff (rst)
    up_pulse |-> !$past(keys.speed_up_n, 3));
  assert property (@(posedge CLK_50M) disable iff (rst)
    down_pulse |-> !$past(keys.speed_down_n, 3));

endmodule

// File: tone_generator.sv
`timescale 1ns/10ps

module tone_generator
  import organ_pkg::*;
(
  input  logic            CLK_50M,
  input  logic            rst,
  input  organ_switches_t switches,
  output audio_sample_t   audio_sample
);

  note_t        note_q;
  half_period_t half_cnt;
  half_period_t reload;
  logic         note_changed;
  logic         tone_bit;

  // Counter runs from half period minus one down to zero
  assign reload       = NOTE_HALF_PERIOD[switches.note] - 1'b1;
  assign note_changed = (switches.note != note_q);

  // ====================
  // Square wave
  // ====================

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      note_q   <= '0;
      half_cnt <= NOTE_HALF_PERIOD[0] - 1'b1;
      tone_bit <= 1'b0;
    end
    else
    begin
      note_q <= switches.note;
      if (note_changed)
        // New note starts a fresh half period
        half_cnt <= reload;
      else if (half_cnt == '0)
      begin
        half_cnt <= reload;
        tone_bit <= ~tone_bit;
      end
      else
        half_cnt <= half_cnt - 1'b1;
    end
  end

  // ====================
  // Sample byte
  // ====================

  // Gated wave mapped onto the signed full scale
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      audio_sample <= SAMPLE_LOW;
    else if (switches.tone_on && tone_bit)
      audio_sample <= SAMPLE_HIGH;
    else
      audio_sample <= SAMPLE_LOW;
  end

  // Counter never runs past the half period of the held note
  assert property (@(posedge CLK_50M) disable iff (rst)
    !note_changed |-> (half_cnt <= reload));

endmodule

// File: led_chaser.sv
`timescale 1ns/10ps

module led_chaser
  import panel_pkg::*;
(
  input  logic CLK_50M,
  input  logic rst,
  input  logic chase_tick,
  output led_t led
);

  chase_state_t state;

  // States are numbered in bounce order, FALL_1 wraps back to RISE_0
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      state <= RISE_0;
    else if (chase_tick)
    begin
      if (state == FALL_1)
        state <= RISE_0;
      else
        state <= chase_state_t'(state + 1'b1);
    end
  end

  // One lit LED per state
  always_comb
  begin
    case (state)
      RISE_0:  led = 8'b0000_0001;
      RISE_1:  led = 8'b0000_0010;
      RISE_2:  led = 8'b0000_0100;
      RISE_3:  led = 8'b0000_1000;
      RISE_4:  led = 8'b0001_0000;
      RISE_5:  led = 8'b0010_0000;
      RISE_6:  led = 8'b0100_0000;
      RISE_7:  led = 8'b1000_0000;
      FALL_6:  led = 8'b0100_0000;
      FALL_5:  led = 8'b0010_0000;
      FALL_4:  led = 8'b0001_0000;
      FALL_3:  led = 8'b0000_1000;
      FALL_2:  led = 8'b0000_0100;
      FALL_1:  led = 8'b0000_0010;
      default: led = 8'b0000_0001;
    endcase
  end

  // Only the fourteen bounce states occur, each with one lit LED
  assert property (@(posedge CLK_50M) disable iff (rst) state <= FALL_1);

endmodule

// File: sample_rate_control.sv
`timescale 1ns/10ps

module sample_rate_control
  import panel_pkg::*;
#(
  parameter int DEFAULT_COUNT = 12499,
  parameter int SPEED_STEP    = 100
)
(
  input  logic          CLK_50M,
  input  logic          rst,
  input  speed_events_t events,
  output sample_count_t sample_count
);

  localparam logic [16:0] STEP_WIDE = 17'(SPEED_STEP);

  logic [16:0] faster;
  logic [16:0] slower;
  logic        faster_ok;
  logic        slower_ok;

  // One spare bit catches wrap in both directions
  assign faster    = {1'b0, sample_count} - STEP_WIDE;
  assign slower    = {1'b0, sample_count} + STEP_WIDE;
  assign faster_ok = !faster[16] && (faster >= STEP_WIDE);
  assign slower_ok = !slower[16];

  // ====================
  // Count register
  // ====================

  // Restore wins, opposing steps in one cycle cancel
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      sample_count <= sample_count_t'(DEFAULT_COUNT);
    else if (events.restore)
      sample_count <= sample_count_t'(DEFAULT_COUNT);
    else if (events.up && !events.down)
    begin
      if (faster_ok)
        sample_count <= faster[15:0];
    end
    else if (events.down && !events.up)
    begin
      if (slower_ok)
        sample_count <= slower[15:0];
    end
  end

  // Lower bound of the range, the upper bound is the width itself
  assert property (@(posedge CLK_50M) disable iff (rst)
    sample_count >= sample_count_t'(SPEED_STEP));

endmodule

// File: hex_display.sv
`timescale 1ns/10ps

module hex_display
  import panel_pkg::*;
(
  input  logic          CLK_50M,
  input  logic          rst,
  input  logic          display_tick,
  input  sample_count_t sample_count,
  output hex_digits_t   hex
);

  logic [23:0] shown;

  // Active-low hex digit, bit 6 is segment g
  function automatic seg_t seg_decode(input logic [3:0] nibble);
    case (nibble)
      4'h0:    return 7'h40;
      4'h1:    return 7'h79;
      4'h2:    return 7'h24;
      4'h3:    return 7'h30;
      4'h4:    return 7'h19;
      4'h5:    return 7'h12;
      4'h6:    return 7'h02;
      4'h7:    return 7'h78;
      4'h8:    return 7'h00;
      4'h9:    return 7'h10;
      4'hA:    return 7'h08;
      4'hB:    return 7'h03;
      4'hC:    return 7'h46;
      4'hD:    return 7'h21;
      4'hE:    return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  // ====================
  // Display latch
  // ====================

  // Frozen between refreshes so the digits stay readable
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      shown <= '0;
    else if (display_tick)
      shown <= {8'h00, sample_count};
  end

  always_comb
  begin
    for (int i = 0; i < 6; i++)
      hex[i] = seg_decode(shown[4*i +: 4]);
  end

endmodule

// File: organ_top.sv
`timescale 1ns/10ps

module organ_top
  import organ_pkg::*;
  import panel_pkg::*;
#(
  parameter int CLKS_PER_MS    = 50000,
  parameter int MS_PER_REPEAT  = 100,
  parameter int MS_PER_DISPLAY = 500,
  parameter int DEFAULT_COUNT  = 12499,
  parameter int SPEED_STEP     = 100
)
(
  input  logic            CLK_50M,
  input  logic            rst,
  input  organ_switches_t switches,
  input  panel_keys_t     keys,
  output led_t            led,
  output hex_digits_t     hex,
  output audio_sample_t   audio_sample
);

  panel_ticks_t  ticks;
  speed_events_t events;
  sample_count_t sample_count;

  organ_control #(
    .CLKS_PER_MS    (CLKS_PER_MS),
    .MS_PER_REPEAT  (MS_PER_REPEAT),
    .MS_PER_DISPLAY (MS_PER_DISPLAY)
  ) u_control (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .keys    (keys),
    .ticks   (ticks),
    .events  (events)
  );

  tone_generator u_tone (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .switches     (switches),
    .audio_sample (audio_sample)
  );

  led_chaser u_chaser (
    .CLK_50M    (CLK_50M),
    .rst        (rst),
    .chase_tick (ticks.chase_tick),
    .led        (led)
  );

  sample_rate_control #(
    .DEFAULT_COUNT (DEFAULT_COUNT),
    .SPEED_STEP    (SPEED_STEP)
  ) u_rate (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .events       (events),
    .sample_count (sample_count)
  );

  hex_display u_hex (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .display_tick (ticks.display_tick),
    .sample_count (sample_count),
    .hex          (hex)
  );

endmodule

// File: tb_organ_model.svh
`ifndef TB_ORGAN_MODEL_SVH
`define TB_ORGAN_MODEL_SVH

// ====================
// Reference model
// ====================

// Half wave length of a note in CLK_50M cycles
function automatic half_period_t model_half_period(input note_t note);
  return NOTE_HALF_PERIOD[note];
endfunction

// LED pattern for bounce position 0 to 13
function automatic led_t chase_led(input int idx);
  if (idx <= 7)
    return led_t'(1 << idx);
  else
    return led_t'(1 << (14 - idx));
endfunction

// One key step, a result out of range leaves the count alone
function automatic sample_count_t step_count(input sample_count_t count, input bit faster);
  int next;
  if (faster)
  begin
    next = int'(count) - SPEED_STEP;
    if (next < SPEED_STEP)
      return count;
  end
  else
  begin
    next = int'(count) + SPEED_STEP;
    if (next > 65535)
      return count;
  end
  return sample_count_t'(next);
endfunction

// Lit segments gfedcba, inverted for the active-low board digits
function automatic seg_t seg_encode(input logic [3:0] nibble);
  logic [6:0] lit;
  case (nibble)
    4'h0:    lit = 7'h3F;
    4'h1:    lit = 7'h06;
    4'h2:    lit = 7'h5B;
    4'h3:    lit = 7'h4F;
    4'h4:    lit = 7'h66;
    4'h5:    lit = 7'h6D;
    4'h6:    lit = 7'h7D;
    4'h7:    lit = 7'h07;
    4'h8:    lit = 7'h7F;
    4'h9:    lit = 7'h6F;
    4'hA:    lit = 7'h77;
    4'hB:    lit = 7'h7C;
    4'hC:    lit = 7'h39;
    4'hD:    lit = 7'h5E;
    4'hE:    lit = 7'h79;
    default: lit = 7'h71;
  endcase
  return ~lit;
endfunction

function automatic hex_digits_t encode_count(input logic [23:0] value);
  hex_digits_t digits;
  for (int d = 0; d < 6; d++)
    digits[d] = seg_encode(value[4*d +: 4]);
  return digits;
endfunction

// ====================
// Compare tasks
// ====================

task automatic check_sample(input string name, input audio_sample_t got,
                            input audio_sample_t expected);
  if (got !== expected)
    report_failure($sformatf("mismatch %s got %h expected %h", name, got, expected));
endtask

task automatic check_led(input string name, input led_t got, input led_t expected);
  if (got !== expected)
    report_failure($sformatf("mismatch %s got %h expected %h", name, got, expected));
endtask

task automatic check_hex(input string name, input hex_digits_t got,
                         input hex_digits_t expected);
  if (got !== expected)
    report_failure($sformatf("mismatch %s got %h expected %h", name, got, expected));
endtask

// Reads the count back from the six digits
task automatic check_count(input string name, input hex_digits_t shown,
                           input sample_count_t expected);
  logic [23:0] value;
  bit          found;
  value = '0;
  for (int d = 0; d < 6; d++)
  begin
    found = 1'b0;
    for (int n = 0; n < 16; n++)
    begin
      if (seg_encode(4'(n)) === shown[d])
      begin
        value[4*d +: 4] = 4'(n);
        found = 1'b1;
      end
    end
    if (!found)
      report_failure($sformatf("digit %0d of %s shows no hex character", d, name));
  end
  if (value !== {8'h00, expected})
    report_failure($sformatf("mismatch %s got %h expected %h", name, value, expected));
endtask

`endif

// File: tb_organ.sv
`timescale 1ns/10ps

module tb_organ
  import organ_pkg::*;
  import panel_pkg::*;
;

  localparam int CLK_PERIOD     = 20;
  localparam int CLKS_PER_MS    = 20;
  localparam int MS_PER_REPEAT  = 5;
  localparam int MS_PER_DISPLAY = 4;
  localparam int DEFAULT_COUNT  = 12499;
  localparam int SPEED_STEP     = 100;

  localparam int DISPLAY_CYCLES = CLKS_PER_MS * MS_PER_DISPLAY;
  localparam int CHASE_CYCLES   = 2 * DISPLAY_CYCLES;
  localparam int REPEAT_CYCLES  = CLKS_PER_MS * MS_PER_REPEAT;
  localparam int SETTLE_CYCLES  = 2 * DISPLAY_CYCLES + 8;
  localparam int CHASE_CHANGES  = 32;
  localparam int NUM_HOLDS      = 12;
  localparam int MAX_HOLD       = 8 * REPEAT_CYCLES;
  localparam int FLOOR_HOLD     = 250 * REPEAT_CYCLES;
  localparam int CEIL_HOLD      = 670 * REPEAT_CYCLES;
  localparam int NUM_NOTES      = 8;
  localparam int GATE_SEGMENTS  = 4;
  localparam int GATE_CYCLES    = 100000;

  logic            CLK_50M;
  logic            rst;
  organ_switches_t switches;
  panel_keys_t     keys;
  led_t            led;
  hex_digits_t     hex;
  audio_sample_t   audio_sample;

  logic [31:0]   rng_state = 32'hfa79bac2;
  sample_count_t model_count;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  `include "tb_organ_model.svh"

  organ_top #(
    .CLKS_PER_MS    (CLKS_PER_MS),
    .MS_PER_REPEAT  (MS_PER_REPEAT),
    .MS_PER_DISPLAY (MS_PER_DISPLAY)
  ) DUT (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .switches     (switches),
    .keys         (keys),
    .led          (led),
    .hex          (hex),
    .audio_sample (audio_sample)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #(CLK_PERIOD / 2) CLK_50M = ~CLK_50M;
  end

  // ====================
  // Helpers
  // ====================

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Outputs are read and inputs driven 2 ns after the edge
  task automatic next_cycle();
    @(posedge CLK_50M);
    #2;
  endtask

  function automatic audio_sample_t other_level(input audio_sample_t level);
    return (level == SAMPLE_HIGH) ? SAMPLE_LOW : SAMPLE_HIGH;
  endfunction

  task automatic run_chaser(input int changes);
    led_t prev;
    int   idx;
    int   waited;
    idx  = 0;
    prev = led;
    for (int k = 0; k < changes; k++)
    begin
      waited = 0;
      while (led === prev)
      begin
        next_cycle();
        waited++;
        if (waited > 2 * CHASE_CYCLES)
          report_failure("LED chaser stopped stepping");
      end
      idx = (idx + 1) % 14;
      check_led("led", led, chase_led(idx));
      prev = led;
    end
  endtask

  // Each display change while the key acts is one step of the model
  task automatic hold_key(input bit faster, input int cycles);
    hex_digits_t last;
    last = hex;
    keys = '1;
    if (faster)
      keys.speed_up_n = 1'b0;
    else
      keys.speed_down_n = 1'b0;
    for (int i = 0; i < cycles + SETTLE_CYCLES; i++)
    begin
      if (i == cycles)
        keys = '1;
      next_cycle();
      if (hex !== last)
      begin
        model_count = step_count(model_count, faster);
        check_count("hex", hex, model_count);
        last = hex;
      end
    end
    check_count("hex", hex, model_count);
  endtask

  task automatic run_pitch(input note_t note);
    audio_sample_t prev;
    audio_sample_t level;
    half_period_t  half;
    int            waited;
    switches = '{note: note, tone_on: 1'b1};
    half     = model_half_period(note);
    // Let the old note's last edge and the register stage pass
    next_cycle();
    next_cycle();
    prev   = audio_sample;
    waited = 0;
    while (audio_sample === prev)
    begin
      next_cycle();
      waited++;
      if (waited > half + 4)
        report_failure($sformatf("audio sample never toggled for note %0d", note));
    end
    if (audio_sample !== SAMPLE_HIGH)
      check_sample("audio_sample", audio_sample, SAMPLE_LOW);
    level = audio_sample;
    for (int edge_n = 0; edge_n < 2; edge_n++)
    begin
      for (int i = 1; i <= half; i++)
      begin
        next_cycle();
        check_sample("audio_sample", audio_sample, (i == half) ? other_level(level) : level);
      end
      level = other_level(level);
    end
  endtask

  task automatic run_gate(input int cycles);
    logic [31:0] r;
    r        = next_random();
    switches = '{note: note_t'(r[2:0]), tone_on: 1'b0};
    for (int i = 0; i < cycles; i++)
    begin
      next_cycle();
      check_sample("audio_sample", audio_sample, SAMPLE_LOW);
    end
  endtask

  // ====================
  // Watchdog
  // ====================

  initial
  begin
    longint total;
    longint worst;
    worst = 0;
    for (int k = 0; k < 8; k++)
      if (NOTE_HALF_PERIOD[k] > worst)
        worst = NOTE_HALF_PERIOD[k];
    total = 8 + (CHASE_CHANGES + 1) * CHASE_CYCLES + 2 * DISPLAY_CYCLES;
    total += NUM_HOLDS * (MAX_HOLD + SETTLE_CYCLES);
    total += FLOOR_HOLD + CEIL_HOLD + 2 * SETTLE_CYCLES;
    total += 2 * DISPLAY_CYCLES + 8 + GATE_SEGMENTS * GATE_CYCLES;
    total += NUM_NOTES * (3 * worst + 8);
    #((total * 12 / 10) * CLK_PERIOD);
    report_failure("timeout, the tests did not finish in time");
  end

  // ====================
  // Test sequence
  // ====================

  initial
  begin
    logic [31:0] r;
    rst         = 1'b1;
    switches    = '{note: '0, tone_on: 1'b0};
    keys        = '1;
    model_count = sample_count_t'(DEFAULT_COUNT);
    repeat (4) next_cycle();
    rst = 1'b0;

    // Reset state of the panel
    check_led("led", led, chase_led(0));
    check_hex("hex", hex, encode_count(24'h0));

    run_chaser(CHASE_CHANGES);

    // No key held for two display periods
    repeat (2 * DISPLAY_CYCLES) next_cycle();
    check_count("hex", hex, model_count);

    for (int h = 0; h < NUM_HOLDS; h++)
    begin
      r = next_random();
      hold_key(r[31], REPEAT_CYCLES + int'(r[15:0]) % (MAX_HOLD - REPEAT_CYCLES));
    end

    // Run into both ends of the range
    hold_key(1'b1, FLOOR_HOLD);
    if (step_count(model_count, 1'b1) != model_count)
      report_failure("sampling count stopped before the lower guard");
    hold_key(1'b0, CEIL_HOLD);
    if (step_count(model_count, 1'b0) != model_count)
      report_failure("sampling count stopped before the upper guard");

    keys.speed_reset_n = 1'b0;
    repeat (DISPLAY_CYCLES) next_cycle();
    keys = '1;
    repeat (DISPLAY_CYCLES + 8) next_cycle();
    model_count = sample_count_t'(DEFAULT_COUNT);
    check_hex("hex", hex, encode_count(24'(DEFAULT_COUNT)));

    for (int n = 0; n < NUM_NOTES; n++)
    begin
      r = next_random();
      run_pitch(note_t'(r[2:0]));
    end

    for (int g = 0; g < GATE_SEGMENTS; g++)
      run_gate(GATE_CYCLES);

    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: sources.f
+incdir+.
organ_pkg.sv
panel_pkg.sv
organ_control.sv
tone_generator.sv
led_chaser.sv
sample_rate_control.sv
hex_display.sv
organ_top.sv
tb_organ.sv
